/* verilog/cpu_consts.svh */
////////////////////////////////////////////////////////////////////////////
// cpu width and size constants
////////////////////////////////////////////////////////////////////////////

`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data path and instruction word width
`define CPU_WORD_W 16

// architectural registers, r0 reads as zero
`define CPU_NUM_REGS 8

// instruction memory byte address, 256 words
`define CPU_IMEM_AW 9

// data memory byte address, 256 words
`define CPU_DMEM_AW 9

`endif

/* verilog/cpu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// cpu opcode and alu operation types
////////////////////////////////////////////////////////////////////////////

package cpu_pkg;

   // instruction opcode, bits 15..12
   // codes 13 and 14 are unassigned and act as nop
   typedef enum logic [3:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_SLL  = 4'd5,
      OP_SRL  = 4'd6,
      OP_SLT  = 4'd7,
      OP_ADDI = 4'd8,
      OP_LW   = 4'd9,
      OP_SW   = 4'd10,
      OP_BEQZ = 4'd11,
      OP_BNEZ = 4'd12,
      OP_HALT = 4'd15
   } opcode_t;

   // alu function select
   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,
      ALU_SRL = 3'd6,
      ALU_SLT = 3'd7
   } alu_op_t;

endpackage

/* verilog/word_mem.sv */
////////////////////////////////////////////////////////////////////////////
// word memory, async read and clocked write
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module word_mem #(
   // byte address width, bit 0 is dropped
   parameter int unsigned addr_w = 9
) (
   input  logic                   clk,
   input  logic                   en,
   input  logic                   wr,
   input  logic [addr_w-1:0]      addr,
   input  logic [`CPU_WORD_W-1:0] wdata,
   output logic [`CPU_WORD_W-1:0] rdata
);

   localparam int unsigned depth = 2 ** (addr_w - 1);

   // word storage
   logic [`CPU_WORD_W-1:0] mem [0:depth-1];

   // word index from byte address
   logic [addr_w-2:0] word_idx;

   assign word_idx = addr[addr_w-1:1];

   ////////////////////////////////////////////////////////////////////////////
   // read path
   ////////////////////////////////////////////////////////////////////////////

   // zero unless a read is actually requested
   assign rdata = (en && !wr) ? mem[word_idx] : '0;

   ////////////////////////////////////////////////////////////////////////////
   // write path
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // same-address read and write in one cycle is not supported
      if (en && wr) begin
         mem[word_idx] <= wdata;
      end
   end

endmodule

/* verilog/reg_file.sv */
////////////////////////////////////////////////////////////////////////////
// register file, two read ports and one write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module reg_file (
   input  logic                   clk,
   input  logic                   rst,
   input  logic [2:0]             ra,
   input  logic [2:0]             rb,
   output logic [`CPU_WORD_W-1:0] rdata_a,
   output logic [`CPU_WORD_W-1:0] rdata_b,
   input  logic                   we,
   input  logic [2:0]             waddr,
   input  logic [`CPU_WORD_W-1:0] wdata
);

   localparam int unsigned num_regs = `CPU_NUM_REGS;

   logic [`CPU_WORD_W-1:0] regs [0:num_regs-1];

   // write port
   // r0 is never written, so entry 0 keeps its reset value
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (waddr != 3'd0)) begin
         regs[waddr] <= wdata;
      end
   end

   // read ports, combinational
   // r0 forced to zero on the read side as well
   always_comb begin
      rdata_a = regs[ra];
      rdata_b = regs[rb];
      if (ra == 3'd0) begin
         rdata_a = '0;
      end
      if (rb == 3'd0) begin
         rdata_b = '0;
      end
   end

endmodule

/* verilog/alu.sv */
////////////////////////////////////////////////////////////////////////////
// 16-bit combinational alu
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module alu (
   input  cpu_pkg::alu_op_t       op,
   input  logic [`CPU_WORD_W-1:0] a,
   input  logic [`CPU_WORD_W-1:0] b,
   output logic [`CPU_WORD_W-1:0] y
);

   // shift amount from low four bits of b
   logic [3:0] shamt;

   // signed compare for slt
   logic lt;

   assign shamt = b[3:0];
   assign lt    = $signed(a) < $signed(b);

   ////////////////////////////////////////////////////////////////////////////
   // operation select
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (op)
         // arithmetic, wraps mod 2^16
         cpu_pkg::ALU_ADD: begin
            y = a + b;
         end
         cpu_pkg::ALU_SUB: begin
            y = a - b;
         end

         // bitwise logic
         cpu_pkg::ALU_AND: begin
            y = a & b;
         end
         cpu_pkg::ALU_OR: begin
            y = a | b;
         end
         cpu_pkg::ALU_XOR: begin
            y = a ^ b;
         end

         // logical shifts
         cpu_pkg::ALU_SLL: begin
            y = a << shamt;
         end
         cpu_pkg::ALU_SRL: begin
            y = a >> shamt;
         end

         // set less than, result is 0 or 1
         cpu_pkg::ALU_SLT: begin
            y = {{(`CPU_WORD_W-1){1'b0}}, lt};
         end

         default: begin
            y = a + b;
         end
      endcase
   end

endmodule

/* verilog/instr_decode.sv */
////////////////////////////////////////////////////////////////////////////
// instruction field split and control decode
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module instr_decode (
   input  logic [`CPU_WORD_W-1:0] instr,
   output logic [2:0]             rd,
   output logic [2:0]             rs,
   output logic [2:0]             rt,
   output logic [`CPU_WORD_W-1:0] imm,
   output cpu_pkg::alu_op_t       alu_op,
   output logic                   use_imm,
   output logic                   reg_we,
   output logic                   mem_rd,
   output logic                   mem_wr,
   output logic                   is_beqz,
   output logic                   is_bnez,
   output logic                   is_halt
);

   cpu_pkg::opcode_t opcode;

   assign opcode = cpu_pkg::opcode_t'(instr[15:12]);

   ////////////////////////////////////////////////////////////////////////////
   // fields
   ////////////////////////////////////////////////////////////////////////////

   assign rd = instr[11:9];
   assign rs = instr[8:6];

   // second read port, store data comes from rd
   assign rt = (opcode == cpu_pkg::OP_SW) ? instr[11:9] : instr[5:3];

   // imm6 sign extended to word width
   assign imm = {{(`CPU_WORD_W-6){instr[5]}}, instr[5:0]};

   ////////////////////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // defaults, also the nop behaviour for codes 13 and 14
      alu_op  = cpu_pkg::ALU_ADD;
      use_imm = 1'b0;
      reg_we  = 1'b0;
      mem_rd  = 1'b0;
      mem_wr  = 1'b0;
      is_beqz = 1'b0;
      is_bnez = 1'b0;
      is_halt = 1'b0;

      case (opcode)
         // r-type, rd = rs op rt
         cpu_pkg::OP_ADD,
         cpu_pkg::OP_SUB,
         cpu_pkg::OP_AND,
         cpu_pkg::OP_OR,
         cpu_pkg::OP_XOR,
         cpu_pkg::OP_SLL,
         cpu_pkg::OP_SRL,
         cpu_pkg::OP_SLT: begin
            alu_op = cpu_pkg::alu_op_t'(instr[14:12]);
            reg_we = 1'b1;
         end
         cpu_pkg::OP_ADDI: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
         end
         // address is rs + imm on the alu add
         cpu_pkg::OP_LW: begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
            mem_rd  = 1'b1;
         end
         cpu_pkg::OP_SW: begin
            use_imm = 1'b1;
            mem_wr  = 1'b1;
         end
         cpu_pkg::OP_BEQZ: begin
            is_beqz = 1'b1;
         end
         cpu_pkg::OP_BNEZ: begin
            is_bnez = 1'b1;
         end
         cpu_pkg::OP_HALT: begin
            is_halt = 1'b1;
         end
         default: begin
         end
      endcase
   end

endmodule

/* verilog/cpu_top.sv */
////////////////////////////////////////////////////////////////////////////
// single-cycle 16-bit cpu core
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   imem_wr,
   input  logic [`CPU_IMEM_AW-1:0] imem_addr,
   input  logic [`CPU_WORD_W-1:0] imem_data,
   input  logic                   start,
   output logic                   retire,
   output logic [`CPU_IMEM_AW-1:0] retire_pc,
   output logic                   wb_en,
   output logic [2:0]             wb_reg,
   output logic [`CPU_WORD_W-1:0] wb_data,
   output logic                   mem_wr,
   output logic [`CPU_DMEM_AW-1:0] mem_addr,
   output logic [`CPU_WORD_W-1:0] mem_wdata,
   output logic                   halted
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_HALT
   } state_t;

   state_t                  state;
   logic [`CPU_IMEM_AW-1:0] pc;
   logic [`CPU_IMEM_AW-1:0] pc_plus2;
   logic [`CPU_IMEM_AW-1:0] br_target;
   logic [`CPU_IMEM_AW-1:0] pc_next;
   logic                    idle;
   logic                    running;
   logic                    br_taken;

   // memory side
   logic [`CPU_IMEM_AW-1:0] im_addr;
   logic                    im_en;
   logic                    im_wr;
   logic [`CPU_WORD_W-1:0]  instr;
   logic [`CPU_WORD_W-1:0]  load_data;

   // decode outputs
   logic [2:0]              rd;
   logic [2:0]              rs;
   logic [2:0]              rt;
   logic [`CPU_WORD_W-1:0]  imm;
   cpu_pkg::alu_op_t        alu_op;
   logic                    use_imm;
   logic                    reg_we;
   logic                    dec_mem_rd;
   logic                    dec_mem_wr;
   logic                    is_beqz;
   logic                    is_bnez;
   logic                    is_halt;

   // datapath
   logic [`CPU_WORD_W-1:0]  rdata_a;
   logic [`CPU_WORD_W-1:0]  rdata_b;
   logic [`CPU_WORD_W-1:0]  alu_b;
   logic [`CPU_WORD_W-1:0]  alu_y;

   assign idle    = (state == ST_IDLE);
   assign running = (state == ST_RUN);

   ////////////////////////////////////////////////////////////////////////////
   // run control and pc
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         pc    <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state <= ST_RUN;
                  pc    <= '0;
               end
            end
            ST_RUN: begin
               // halt freezes pc on the halt instruction
               if (is_halt) begin
                  state <= ST_HALT;
               end else begin
                  pc <= pc_next;
               end
            end
            default: begin
               // halted until reset
            end
         endcase
      end
   end

   // branch on rs zero / nonzero, offset in halfwords
   assign pc_plus2  = pc + `CPU_IMEM_AW'(2);
   assign br_target = pc_plus2 + {imm[`CPU_IMEM_AW-2:0], 1'b0};
   assign br_taken  = (is_beqz && (rdata_a == '0)) || (is_bnez && (rdata_a != '0));
   assign pc_next   = br_taken ? br_target : pc_plus2;

   ////////////////////////////////////////////////////////////////////////////
   // instruction memory, load port while idle
   ////////////////////////////////////////////////////////////////////////////

   assign im_addr = idle ? imem_addr : pc;
   assign im_wr   = idle && imem_wr;
   assign im_en   = im_wr || running;

   word_mem #(.addr_w(`CPU_IMEM_AW)) imem_inst (
      .clk   (clk),
      .en    (im_en),
      .wr    (im_wr),
      .addr  (im_addr),
      .wdata (imem_data),
      .rdata (instr)
   );

   instr_decode instr_decode_inst (
      .instr   (instr),
      .rd      (rd),
      .rs      (rs),
      .rt      (rt),
      .imm     (imm),
      .alu_op  (alu_op),
      .use_imm (use_imm),
      .reg_we  (reg_we),
      .mem_rd  (dec_mem_rd),
      .mem_wr  (dec_mem_wr),
      .is_beqz (is_beqz),
      .is_bnez (is_bnez),
      .is_halt (is_halt)
   );

   ////////////////////////////////////////////////////////////////////////////
   // execute and writeback
   ////////////////////////////////////////////////////////////////////////////

   reg_file reg_file_inst (
      .clk     (clk),
      .rst     (rst),
      .ra      (rs),
      .rb      (rt),
      .rdata_a (rdata_a),
      .rdata_b (rdata_b),
      .we      (wb_en),
      .waddr   (rd),
      .wdata   (wb_data)
   );

   assign alu_b = use_imm ? imm : rdata_b;

   alu alu_inst (
      .op (alu_op),
      .a  (rdata_a),
      .b  (alu_b),
      .y  (alu_y)
   );

   // data memory, address from alu sum, store data is rd via port b
   word_mem #(.addr_w(`CPU_DMEM_AW)) dmem_inst (
      .clk   (clk),
      .en    (running && (dec_mem_rd || dec_mem_wr)),
      .wr    (mem_wr),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .rdata (load_data)
   );

   // trace outputs double as the real write strobes
   assign retire    = running;
   assign retire_pc = pc;
   assign wb_en     = running && reg_we && (rd != 3'd0);
   assign wb_reg    = rd;
   assign wb_data   = dec_mem_rd ? load_data : alu_y;
   assign mem_wr    = running && dec_mem_wr;
   assign mem_addr  = alu_y[`CPU_DMEM_AW-1:0];
   assign mem_wdata = rdata_b;
   assign halted    = (state == ST_HALT);

endmodule

/* verif/cpu_checker.sv */
////////////////////////////////////////////////////////////////////////////
// cpu reference model and trace checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_checker (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    imem_wr,
   input  logic [`CPU_IMEM_AW-1:0] imem_addr,
   input  logic [`CPU_WORD_W-1:0]  imem_data,
   input  logic                    start,
   input  logic                    retire,
   input  logic [`CPU_IMEM_AW-1:0] retire_pc,
   input  logic                    wb_en,
   input  logic [2:0]              wb_reg,
   input  logic [`CPU_WORD_W-1:0]  wb_data,
   input  logic                    mem_wr,
   input  logic [`CPU_DMEM_AW-1:0] mem_addr,
   input  logic [`CPU_WORD_W-1:0]  mem_wdata,
   input  logic                    halted,
   output int                      errors,
   output int                      model_halts,
   output int                      dut_halts
);

   typedef enum logic [1:0] {
      M_IDLE,
      M_RUN,
      M_HALT
   } model_state_t;

   // architectural state of the model
   model_state_t            mstate;
   logic [`CPU_IMEM_AW-1:0] mpc;
   logic [`CPU_WORD_W-1:0]  mregs [0:`CPU_NUM_REGS-1];
   logic [`CPU_WORD_W-1:0]  img [0:(2**(`CPU_IMEM_AW-1))-1];
   // data image, kept across resets like the core's memory
   logic [`CPU_WORD_W-1:0]  mdmem [0:(2**(`CPU_DMEM_AW-1))-1];
   logic                    halted_q;

   int err_count   = 0;
   int model_count = 0;
   int dut_count   = 0;

   assign errors      = err_count;
   assign model_halts = model_count;
   assign dut_halts   = dut_count;

   task automatic compare_field(input string name, input logic [15:0] exp,
                                input logic [15:0] got);
      if (got !== exp) begin
         err_count++;
         $display("Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   // no retire and no writes while idle or halted
   task automatic check_quiet(input logic exp_halted);
      compare_field("retire", 16'(1'b0), 16'(retire));
      compare_field("wb_en", 16'(1'b0), 16'(wb_en));
      compare_field("mem_wr", 16'(1'b0), 16'(mem_wr));
      compare_field("halted", 16'(exp_halted), 16'(halted));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // one instruction of the model, compared against the trace
   ////////////////////////////////////////////////////////////////////////////

   task automatic execute_step();
      logic [15:0]      ins;
      cpu_pkg::opcode_t op;
      logic [2:0]       rd;
      logic [2:0]       rs;
      logic [2:0]       rt;
      logic [15:0]      imm;
      logic [15:0]      a;
      logic [15:0]      b;
      logic [15:0]      res;
      logic [15:0]      sum;
      logic [8:0]       addr;
      logic [8:0]       next_pc;
      logic             we;
      logic             st;
      logic             halt;
      ins     = img[mpc[8:1]];
      op      = cpu_pkg::opcode_t'(ins[15:12]);
      rd      = ins[11:9];
      rs      = ins[8:6];
      rt      = ins[5:3];
      imm     = {{10{ins[5]}}, ins[5:0]};
      a       = mregs[rs];
      b       = mregs[rt];
      sum     = a + imm;
      addr    = sum[8:0];
      res     = '0;
      we      = 1'b0;
      st      = 1'b0;
      halt    = 1'b0;
      next_pc = mpc + 9'd2;
      case (op)
         cpu_pkg::OP_ADD: begin
            res = a + b;
            we  = 1'b1;
         end
         cpu_pkg::OP_SUB: begin
            res = a - b;
            we  = 1'b1;
         end
         cpu_pkg::OP_AND: begin
            res = a & b;
            we  = 1'b1;
         end
         cpu_pkg::OP_OR: begin
            res = a | b;
            we  = 1'b1;
         end
         cpu_pkg::OP_XOR: begin
            res = a ^ b;
            we  = 1'b1;
         end
         // shift by low four bits of rt
         cpu_pkg::OP_SLL: begin
            res = a << b[3:0];
            we  = 1'b1;
         end
         cpu_pkg::OP_SRL: begin
            res = a >> b[3:0];
            we  = 1'b1;
         end
         cpu_pkg::OP_SLT: begin
            res = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            we  = 1'b1;
         end
         cpu_pkg::OP_ADDI: begin
            res = sum;
            we  = 1'b1;
         end
         cpu_pkg::OP_LW: begin
            res = mdmem[addr[8:1]];
            we  = 1'b1;
         end
         cpu_pkg::OP_SW: begin
            st = 1'b1;
         end
         // target is pc + 2 + 2 * imm6
         cpu_pkg::OP_BEQZ: begin
            if (a == 16'd0) begin
               next_pc = mpc + 9'd2 + {imm[7:0], 1'b0};
            end
         end
         cpu_pkg::OP_BNEZ: begin
            if (a != 16'd0) begin
               next_pc = mpc + 9'd2 + {imm[7:0], 1'b0};
            end
         end
         cpu_pkg::OP_HALT: begin
            halt = 1'b1;
         end
         default: begin
         end
      endcase

      compare_field("retire", 16'(1'b1), 16'(retire));
      compare_field("retire_pc", 16'(mpc), 16'(retire_pc));
      compare_field("halted", 16'(1'b0), 16'(halted));
      // r0 target shows no write
      compare_field("wb_en", 16'(we && rd != 3'd0), 16'(wb_en));
      if (we && rd != 3'd0) begin
         compare_field("wb_reg", 16'(rd), 16'(wb_reg));
         compare_field("wb_data", res, wb_data);
      end
      compare_field("mem_wr", 16'(st), 16'(mem_wr));
      if (st) begin
         compare_field("mem_addr", 16'(addr), 16'(mem_addr));
         compare_field("mem_wdata", mregs[rd], mem_wdata);
      end

      // commit model state
      if (st) begin
         mdmem[addr[8:1]] = mregs[rd];
      end
      if (we && rd != 3'd0) begin
         mregs[rd] = res;
      end
      if (halt) begin
         mstate = M_HALT;
         model_count++;
      end else begin
         mpc = next_pc;
      end
   endtask

   // sampled mid-cycle, away from the edge that drives stimulus
   always @(negedge clk) begin
      if (rst) begin
         mstate   = M_IDLE;
         mpc      = '0;
         halted_q = 1'b0;
         for (int i = 0; i < `CPU_NUM_REGS; i++) begin
            mregs[i] = '0;
         end
      end else begin
         if (halted === 1'b1 && !halted_q) begin
            dut_count++;
         end
         halted_q = halted;
         case (mstate)
            M_IDLE: begin
               check_quiet(1'b0);
               // mirror of the load port
               if (imem_wr) begin
                  img[imem_addr[`CPU_IMEM_AW-1:1]] = imem_data;
               end
               if (start) begin
                  mstate = M_RUN;
                  mpc    = '0;
               end
            end
            M_RUN: begin
               execute_step();
            end
            default: begin
               check_quiet(1'b1);
            end
         endcase
      end
   end

endmodule

/* verif/cpu_tb.sv */
////////////////////////////////////////////////////////////////////////////
// cpu random program testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "cpu_consts.svh"

module cpu_tb;

   localparam int num_progs    = 3;
   localparam int rand_instrs  = 40;
   localparam int halt_timeout = 400;
   localparam int hold_cycles  = 20;
   localparam int imem_words   = 2 ** (`CPU_IMEM_AW - 1);

   logic                    clk;
   logic                    rst;
   logic                    imem_wr;
   logic [`CPU_IMEM_AW-1:0] imem_addr;
   logic [`CPU_WORD_W-1:0]  imem_data;
   logic                    start;
   logic                    retire;
   logic [`CPU_IMEM_AW-1:0] retire_pc;
   logic                    wb_en;
   logic [2:0]              wb_reg;
   logic [`CPU_WORD_W-1:0]  wb_data;
   logic                    mem_wr;
   logic [`CPU_DMEM_AW-1:0] mem_addr;
   logic [`CPU_WORD_W-1:0]  mem_wdata;
   logic                    halted;

   int          chk_errors;
   int          model_halts;
   int          dut_halts;
   int          tb_errors;
   int          runs_done;
   int          prog_len;
   logic        timed_out;
   logic [15:0] lfsr;
   logic [15:0] prog [0:imem_words-1];

   cpu_top cpu_top_inst (
      .clk       (clk),
      .rst       (rst),
      .imem_wr   (imem_wr),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .start     (start),
      .retire    (retire),
      .retire_pc (retire_pc),
      .wb_en     (wb_en),
      .wb_reg    (wb_reg),
      .wb_data   (wb_data),
      .mem_wr    (mem_wr),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .halted    (halted)
   );

   cpu_checker cpu_checker_inst (
      .clk         (clk),
      .rst         (rst),
      .imem_wr     (imem_wr),
      .imem_addr   (imem_addr),
      .imem_data   (imem_data),
      .start       (start),
      .retire      (retire),
      .retire_pc   (retire_pc),
      .wb_en       (wb_en),
      .wb_reg      (wb_reg),
      .wb_data     (wb_data),
      .mem_wr      (mem_wr),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .halted      (halted),
      .errors      (chk_errors),
      .model_halts (model_halts),
      .dut_halts   (dut_halts)
   );

   // 8 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // random source
   ////////////////////////////////////////////////////////////////////////////

   // fibonacci form, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one step per bit taken
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r    = {r[14:0], lfsr[0]};
      end
      return r;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // program generation
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [15:0] random_instr();
      logic [15:0] bits;
      logic [3:0]  op;
      logic [2:0]  rd;
      logic [2:0]  rs;
      logic [5:0]  imm;
      bits = take_bits(4);
      op   = bits[3:0];
      bits = take_bits(3);
      rd   = bits[2:0];
      bits = take_bits(3);
      rs   = bits[2:0];
      bits = take_bits(6);
      imm  = bits[5:0];
      // halt only at the end, code 15 becomes a nop
      if (op == 4'd15) begin
         op = 4'd13;
      end
      // loads and stores stay in bytes 0..31, base r0
      if (op == cpu_pkg::OP_LW || op == cpu_pkg::OP_SW) begin
         rs     = 3'd0;
         imm[5] = 1'b0;
      end
      // forward branches only
      if (op == cpu_pkg::OP_BEQZ || op == cpu_pkg::OP_BNEZ) begin
         imm[5] = 1'b0;
      end
      return {op, rd, rs, imm};
   endfunction

   // halt words past the program, low bits carry the word index
   function automatic logic [15:0] fill_word(input int idx);
      logic [7:0] w;
      w = 8'(idx);
      return {4'hF, 4'h5, w};
   endfunction

   task automatic build_program(input int pnum);
      logic [5:0] off;
      prog_len = 0;
      // first run defines the low data words with zero stores
      if (pnum == 0) begin
         for (int k = 0; k < 16; k++) begin
            off            = 6'(2 * k);
            prog[prog_len] = {cpu_pkg::OP_SW, 3'd0, 3'd0, off};
            prog_len++;
         end
      end
      for (int i = 0; i < rand_instrs; i++) begin
         prog[prog_len] = random_instr();
         prog_len++;
      end
      prog[prog_len] = {cpu_pkg::OP_HALT, 12'h000};
      prog_len++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // sequencing
   ////////////////////////////////////////////////////////////////////////////

   task automatic apply_reset();
      @(posedge clk);
      rst <= 1'b1;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
   endtask

   // whole instruction memory, program then fill
   task automatic load_program();
      for (int i = 0; i < imem_words; i++) begin
         @(posedge clk);
         imem_wr   <= 1'b1;
         imem_addr <= 9'(2 * i);
         imem_data <= (i < prog_len) ? prog[i] : fill_word(i);
      end
      @(posedge clk);
      imem_wr <= 1'b0;
   endtask

   task automatic pulse_start();
      @(posedge clk);
      start <= 1'b1;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_for_halt();
      int cycles;
      cycles = 0;
      while (halted !== 1'b1 && cycles < halt_timeout) begin
         @(negedge clk);
         cycles++;
      end
      if (halted !== 1'b1) begin
         $display("timeout: core did not halt within %0d cycles", halt_timeout);
         timed_out = 1'b1;
      end
   endtask

   task automatic run_program(input int pnum);
      apply_reset();
      // idle gap, checker expects a quiet core here
      repeat (4) @(posedge clk);
      build_program(pnum);
      load_program();
      repeat (2) @(posedge clk);
      pulse_start();
      wait_for_halt();
      // hold window, no retire allowed after halt
      if (!timed_out) begin
         runs_done++;
         repeat (hold_cycles) @(posedge clk);
      end
   endtask

   initial begin
      rst       = 1'b1;
      imem_wr   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      start     = 1'b0;
      lfsr      = 16'd68;
      tb_errors = 0;
      runs_done = 0;
      timed_out = 1'b0;
      for (int p = 0; p < num_progs; p++) begin
         if (!timed_out) begin
            run_program(p);
         end
      end
      if (model_halts != runs_done || dut_halts != runs_done) begin
         $display("halt count mismatch: expected %0d, model %0d, core %0d",
                  runs_done, model_halts, dut_halts);
         tb_errors++;
      end
      $display("errors: checker %0d, testbench %0d, timeout %0d",
               chk_errors, tb_errors, timed_out);
      if (timed_out || chk_errors != 0 || tb_errors != 0) begin
         $display("Test failures found");
      end else begin
         $display("All tests passed!");
      end
      $finish;
   end

endmodule

/* project.f */
+incdir+verilog
verilog/cpu_pkg.sv
verilog/word_mem.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/instr_decode.sv
verilog/cpu_top.sv
verif/cpu_checker.sv
verif/cpu_tb.sv

/* Makefile */
# verilator build and run of the cpu testbench

sim:
	verilator --binary --timing -f project.f --top-module cpu_tb -Mdir obj_dir
	./obj_dir/Vcpu_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
